// File: rtl/mvm_defs.svh
`ifndef MVM_DEFS_SVH
`define MVM_DEFS_SVH

// --------------------------------------------------
// Stream and flit widths
// --------------------------------------------------
`define MVM_DATAW          32
`define MVM_USERW          2
// Operation code sits above the data word
`define MVM_FLITW          34

// --------------------------------------------------
// Compute tile
// --------------------------------------------------
`define MVM_IPRECISION     8
`define MVM_OPRECISION     32
`define MVM_LANES          4
`define MVM_LINK_DEPTH     4
// Start strobe to result, in cycles
`define MVM_DATAPATH_DELAY 2

`endif

// File: rtl/stream_pkg.sv
`include "mvm_defs.svh"

package stream_pkg;

    // Side-band operation code carried on tuser
    typedef enum logic [`MVM_USERW-1:0] {
        OP_WEIGHT   = 2'd0,
        OP_INPUT    = 2'd1,
        OP_CMD      = 2'd2,
        // Accepted by the ingress and discarded there
        OP_RESERVED = 2'd3
    } op_e;

    // Raw data word of a flit
    typedef logic [`MVM_DATAW-1:0] flit_data_t;

    // Flit as it crosses the link, opcode in the top bits
    typedef struct packed {
        op_e        op;
        flit_data_t data;
    } flit_t;

endpackage

// File: rtl/mvm_pkg.sv
`include "mvm_defs.svh"

package mvm_pkg;

    // One signed input lane
    typedef logic signed [`MVM_IPRECISION-1:0] lane_t;

    // Lane 0 is the least significant byte
    typedef lane_t [`MVM_LANES-1:0] lanes_t;

    // --------------------------------------------------
    // Command word layout, last in bit 0
    // --------------------------------------------------
    typedef struct packed {
        logic [`MVM_DATAW-4:0] rsvd;
        // Copy accumulator to the result stream, then zero it
        logic                  release_acc;
        // Zero the accumulator
        logic                  clear_acc;
        // End of packet marker for the released beat
        logic                  last;
    } cmd_t;

    // Same data word, read as lanes or as a command
    typedef union packed {
        lanes_t lanes;
        cmd_t   cmd;
    } payload_u;

    // Accumulated dot product, wraps in two's complement
    typedef logic signed [`MVM_OPRECISION-1:0] acc_t;

endpackage

// File: rtl/stream_ingress.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module stream_ingress (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  logic [`MVM_DATAW-1:0] s_tdata,
    input  stream_pkg::op_e       s_tuser,
    output logic                  in_valid,
    input  logic                  in_ready,
    output stream_pkg::flit_t     in_flit
);
    import stream_pkg::*;

    logic s_fire;
    logic keep_beat;

    // Slot is free when empty or draining in this cycle
    assign s_tready  = !in_valid || in_ready;
    assign s_fire    = s_tvalid && s_tready;
    // Reserved beats are consumed but never loaded
    assign keep_beat = s_fire && (s_tuser != OP_RESERVED);

    // --------------------------------------------------
    // Output slot control
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
        end else if (keep_beat) begin
            in_valid <= 1'b1;
        end else if (in_ready) begin
            in_valid <= 1'b0;
        end
    end

    // Pack opcode above the data word
    always_ff @(posedge clk) begin
        if (keep_beat) begin
            in_flit <= '{op: s_tuser, data: s_tdata};
        end
    end

    // Flit held while the FIFO pushes back
    a_in_flit_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_flit)
    );

endmodule

// File: rtl/link_fifo.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module link_fifo #(
    parameter int DEPTH = `MVM_LINK_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  stream_pkg::flit_t in_flit,
    output logic              link_valid,
    input  logic              link_ready,
    output stream_pkg::flit_t link_flit
);
    import stream_pkg::*;

    localparam int PTRW = $clog2(DEPTH);
    localparam logic [PTRW:0] FULL_COUNT = (PTRW + 1)'(DEPTH);

    // Flit storage
    logic [`MVM_FLITW-1:0] mem [DEPTH];
    logic [PTRW-1:0]       wr_ptr;
    logic [PTRW-1:0]       rd_ptr;
    // One bit wider than the pointers to tell full from empty
    logic [PTRW:0]         count;
    logic                  wr_en;
    logic                  rd_en;

    assign in_ready   = (count != FULL_COUNT);
    assign link_valid = (count != '0);
    assign wr_en      = in_valid && in_ready;
    assign rd_en      = link_valid && link_ready;
    // Head of the queue is visible the cycle after its write
    assign link_flit  = flit_t'(mem[rd_ptr]);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own since DEPTH is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= FULL_COUNT
    );

    // Reads only land where the pointers show a stored flit
    a_no_empty_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> (wr_ptr != rd_ptr) || (count == FULL_COUNT)
    );

endmodule

// File: rtl/dot_product_unit.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module dot_product_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  mvm_pkg::lanes_t vec,
    input  mvm_pkg::lanes_t weights,
    output logic            done,
    output mvm_pkg::acc_t   result
);
    import mvm_pkg::*;

    // Stage one, full-width signed lane products
    logic signed [2*`MVM_IPRECISION-1:0] prod_q [`MVM_LANES];
    logic                                prod_valid_q;
    // Stage two, adder tree output
    acc_t                                sum_d;
    acc_t                                sum_q;
    logic                                sum_valid_q;

    // --------------------------------------------------
    // Valid bits travel with the data
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid_q <= 1'b0;
            sum_valid_q  <= 1'b0;
        end else begin
            prod_valid_q <= start;
            sum_valid_q  <= prod_valid_q;
        end
    end

    // Products captured only on a start strobe
    always_ff @(posedge clk) begin
        if (start) begin
            for (int i = 0; i < `MVM_LANES; i++) begin
                prod_q[i] <= $signed(vec[i]) * $signed(weights[i]);
            end
        end
    end

    // Sign-extend each product before summing
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < `MVM_LANES; i++) begin
            sum_d = sum_d + acc_t'(prod_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid_q) begin
            sum_q <= sum_d;
        end
    end

    assign done   = sum_valid_q;
    assign result = sum_q;

endmodule

// File: rtl/mvm_tile.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module mvm_tile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              link_valid,
    output logic              link_ready,
    input  stream_pkg::flit_t link_flit,
    output logic              m_tvalid,
    input  logic              m_tready,
    output mvm_pkg::acc_t     m_tdata,
    output logic              m_tlast
);
    import stream_pkg::*;
    import mvm_pkg::*;

    // Room for every vector the pipeline can hold
    localparam int INFW = $clog2(`MVM_DATAPATH_DELAY + 2);

    payload_u        payload;
    lanes_t          weights_q;
    acc_t            acc_q;
    logic [INFW-1:0] inflight_q;
    logic            is_cmd;
    logic            cmd_ok;
    logic            flit_fire;
    logic            load_w;
    logic            start_dp;
    logic            do_release;
    logic            do_clear;
    logic            dp_done;
    acc_t            dp_result;

    // --------------------------------------------------
    // Flit decode
    // --------------------------------------------------
    assign payload    = link_flit.data;
    assign is_cmd     = (link_flit.op == OP_CMD);
    // Commands wait for a drained pipeline and a free result slot
    assign cmd_ok     = (inflight_q == '0) && (!m_tvalid || m_tready);
    assign link_ready = !is_cmd || cmd_ok;
    assign flit_fire  = link_valid && link_ready;
    assign load_w     = flit_fire && (link_flit.op == OP_WEIGHT);
    assign start_dp   = flit_fire && (link_flit.op == OP_INPUT);
    assign do_release = flit_fire && is_cmd && payload.cmd.release_acc;
    assign do_clear   = flit_fire && is_cmd && payload.cmd.clear_acc;

    dot_product_unit dp_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start_dp),
        .vec     (payload.lanes),
        .weights (weights_q),
        .done    (dp_done),
        .result  (dp_result)
    );

    // --------------------------------------------------
    // Weights, in-flight count and accumulator
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights_q  <= '0;
            inflight_q <= '0;
            acc_q      <= '0;
        end else begin
            if (load_w) begin
                weights_q <= payload.lanes;
            end
            case ({start_dp, dp_done})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
            // No done can land here, commands need an empty pipeline
            if (do_release || do_clear) begin
                acc_q <= '0;
            end else if (dp_done) begin
                acc_q <= acc_q + dp_result;
            end
        end
    end

    // Result slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid <= 1'b0;
        end else if (do_release) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (do_release) begin
            m_tdata <= acc_q;
            m_tlast <= payload.cmd.last;
        end
    end

    a_result_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
    );

    // Count matches the depth of the dot-product pipeline
    a_inflight_bound: assert property (
        @(posedge clk) disable iff (!rst_n) inflight_q <= `MVM_DATAPATH_DELAY
    );

endmodule

// File: rtl/mvm_top.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module mvm_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // --------------------------------------------------
    // Input stream
    // --------------------------------------------------
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  logic [`MVM_DATAW-1:0] s_tdata,
    input  stream_pkg::op_e       s_tuser,

    // --------------------------------------------------
    // Result stream
    // --------------------------------------------------
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output mvm_pkg::acc_t         m_tdata,
    output logic                  m_tlast
);
    import stream_pkg::*;

    // Ingress into the link
    logic  in_valid;
    logic  in_ready;
    flit_t in_flit;

    // Link out to the tile
    logic  link_valid;
    logic  link_ready;
    flit_t link_flit;

    stream_ingress ingress_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_flit  (in_flit)
    );

    link_fifo link_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_flit    (in_flit),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .link_flit  (link_flit)
    );

    mvm_tile tile_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .link_flit  (link_flit),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tdata    (m_tdata),
        .m_tlast    (m_tlast)
    );

endmodule

// File: testbench/mvm_tb.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module mvm_tb;

    // --------------------------------------------------
    // DUT signals
    // --------------------------------------------------
    logic                  clk;
    logic                  rst_n;
    logic                  s_tvalid;
    logic                  s_tready;
    logic [`MVM_DATAW-1:0] s_tdata;
    stream_pkg::op_e       s_tuser;
    logic                  m_tvalid;
    logic                  m_tready;
    mvm_pkg::acc_t         m_tdata;
    logic                  m_tlast;

    // Stimulus beats in file order
    int          stim_op[$];
    logic [31:0] stim_data[$];
    // Expected results, head is the next one due
    logic [31:0] exp_value[$];
    logic        exp_last[$];
    int          exp_test[$];
    // Per test bookkeeping
    string       test_name[$];
    int          test_left[$];
    int          test_errs[$];

    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          file_lines;
    int          cycles;
    int          cycle_limit;
    // Separate LCG states for beat gaps and result stalls
    logic [31:0] idle_seed;
    logic [31:0] stall_seed;

    mvm_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tuser  (s_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // LCG step, upper half of the state
    function automatic logic [15:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state[31:16];
    endfunction

    // --------------------------------------------------
    // Data file reader
    // --------------------------------------------------
    task automatic load_testdata();
        int          fd;
        string       line;
        string       name;
        int          op;
        int          last;
        logic [31:0] value;
        fd = $fopen("testbench/mvm_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/mvm_testdata.txt, nothing was run");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                file_lines++;
                if (line.len() > 0) begin
                    case (line[0])
                        "T": begin
                            void'($sscanf(line, "T %s", name));
                            test_name.push_back(name);
                            test_left.push_back(0);
                            test_errs.push_back(0);
                        end
                        "S": begin
                            void'($sscanf(line, "S %d %h", op, value));
                            stim_op.push_back(op);
                            stim_data.push_back(value);
                        end
                        "E": begin
                            void'($sscanf(line, "E %h %d", value, last));
                            exp_value.push_back(value);
                            exp_last.push_back(last[0]);
                            exp_test.push_back(test_name.size() - 1);
                            test_left[test_name.size() - 1]++;
                        end
                        // Comments and blank lines
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send_beat(input int op, input logic [31:0] data);
        logic accepted;
        s_tvalid = 1'b1;
        s_tuser  = stream_pkg::op_e'(op[1:0]);
        s_tdata  = data;
        accepted = 1'b0;
        // s_tready only moves on clock edges, so mid-cycle is safe
        while (!accepted) begin
            accepted = s_tready;
            @(posedge clk);
            #1;
        end
        s_tvalid = 1'b0;
    endtask

    // --------------------------------------------------
    // Result checking against the head of the queue
    // --------------------------------------------------
    task automatic check_result();
        int t;
        if (exp_value.size() == 0) begin
            $display("Result %h arrived at %0t when no result was expected", m_tdata, $time);
            errors++;
        end else begin
            t = exp_test[0];
            if (m_tdata !== exp_value[0] || m_tlast !== exp_last[0]) begin
                $display("FAILED at %0t: %s expected %h last %0b, got %h last %0b",
                         $time, test_name[t], exp_value[0], exp_last[0], m_tdata, m_tlast);
                errors++;
                test_errs[t]++;
            end
            void'(exp_value.pop_front());
            void'(exp_last.pop_front());
            void'(exp_test.pop_front());
            test_left[t]--;
            if (test_left[t] == 0) begin
                if (test_errs[t] == 0) begin
                    tests_passed++;
                end else begin
                    tests_failed++;
                end
                $display("Test %s finished with %0d mismatches", test_name[t], test_errs[t]);
            end
        end
    endtask

    // Stall the result stream on about a third of the cycles
    always @(posedge clk) begin
        #1;
        m_tready = (lcg_next(stall_seed) % 16'd3) != 16'd0;
    end

    // Both handshake signals are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && m_tvalid && m_tready) begin
            check_result();
        end
    end

    // Cycle budget grows with the data file
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout with %0d results still missing after %0d cycles",
                     exp_value.size(), cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int idle;
        clk          = 1'b0;
        rst_n        = 1'b0;
        s_tvalid     = 1'b0;
        s_tdata      = '0;
        s_tuser      = stream_pkg::OP_WEIGHT;
        m_tready     = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        file_lines   = 0;
        cycles       = 0;
        cycle_limit  = 0;
        idle_seed    = 32'd82;
        stall_seed   = 32'd82;
        load_testdata();
        cycle_limit = 40 * file_lines + 200;
        // Reset held for 4 cycles
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < stim_op.size(); i++) begin
            // Zero to two idle cycles before each beat
            idle = int'(lcg_next(idle_seed) % 16'd3);
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            send_beat(stim_op[i], stim_data[i]);
        end
        while (exp_value.size() != 0) begin
            @(posedge clk);
        end
        // Extra cycles catch a stray result
        repeat (10) @(posedge clk);
        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/mvm_testdata.txt
# T name | S op hexdata | E hexvalue last
# op 0 weight, 1 input, 2 command, 3 reserved; command bits 2 release, 1 clear, 0 last
T single_dot
S 0 04030201
S 1 05FF0302
S 2 00000005
E 00000019 1
T accumulate_negative
S 0 80FE7F03
S 1 7F80017F
S 1 01FF02FE
S 1 80007FFF
S 2 00000005
E 000042F4 1
T reload_clear
S 1 00000101
S 2 00000002
S 0 01020304
S 1 FC0A0B0C
S 2 00000004
E 00000061 0
T reserved_op
S 1 01010101
S 3 DEADBEEF
S 1 02020202
S 2 00000005
E 0000001E 1
T backpressure
S 0 02FF0103
S 1 01020304
S 1 10F0FF7F
S 2 00000004
E 000001BB 0
S 1 80808080
S 1 05050505
S 1 FFFFFFFF
S 2 00000004
E FFFFFD94 0
S 1 7F7F7F7F
S 1 7F7F7F7F
S 2 00000005
E 000004F6 1

// File: files.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/mvm_pkg.sv
rtl/stream_ingress.sv
rtl/link_fifo.sv
rtl/dot_product_unit.sv
rtl/mvm_tile.sv
rtl/mvm_top.sv
testbench/mvm_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f files.f --top-module mvm_tb \
    && ./obj_dir/Vmvm_tb | tee /dev/stderr | grep -q "Simulation passed" \
    || exit 1
